// File: flow.f
design/flow_pkg.sv
design/class_splitter.sv
design/lane_fifo.sv
design/dfcontrol.sv
design/lane_merger.sv
design/flow_top.sv
test/flow_tb.sv

// File: Makefile
# Verilator build and run for the two-lane flow path

VERILATOR ?= verilator
TOP       ?= flow_tb
FILELIST  ?= flow.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qF 'All tests passed!' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/flow_tb.sv
/*
 * testbench for the two-lane flow path
 * random producer and consumer on the four-phase handshakes, one model queue per lane,
 * output stall, almost-full priority and parity error tests with a cycle watchdog
 */

`timescale 1ns/1ps

module flow_tb;

    localparam int DATA_W   = 8;
    localparam int DEPTH    = 8;
    localparam int AF_LEVEL = 6;
    localparam int AE_LEVEL = 1;
    localparam int WORD_W   = DATA_W + flow_pkg::WORD_EXTRA;
    localparam int CLS      = DATA_W + flow_pkg::CLASS_POS;  // class bit of a word
    localparam int PAR      = DATA_W + flow_pkg::PARITY_POS; // parity bit of a word

    localparam int N_RANDOM = 60;        // words in the random traffic test
    localparam int N_STALL  = DEPTH + 2; // merger + full FIFO + the word that gets blocked
    localparam int N_PRIO   = 3 + DEPTH;
    localparam int N_PARITY = 11;
    localparam int LIMIT    = 200 * (N_RANDOM + N_STALL + N_PRIO + N_PARITY) + 1000;

    logic              clk;
    logic              reset;
    logic              in_req;
    logic [WORD_W-1:0] in_data;
    logic              in_ack;
    logic              out_req;
    logic [WORD_W-1:0] out_data;
    logic              out_ack;
    logic              error;

    logic [WORD_W-1:0] q0[$];          // accepted lane 0 words, oldest first
    logic [WORD_W-1:0] q1[$];
    logic [WORD_W-1:0] out_log[$];     // every word the consumer took, in order
    logic [WORD_W-1:0] lane0_words[$]; // lane 0 words of the priority test
    bit                stall;          // consumer ignores out_req while set
    int                max_delay;
    int                errors;
    int                sent;
    int                received;
    int                cycles;
    int                tests_run;
    int                tests_failed;
    int                test_err0;
    string             test_name;

    flow_top #(.DATA_W(DATA_W), .DEPTH(DEPTH), .AF_LEVEL(AF_LEVEL), .AE_LEVEL(AE_LEVEL)) dut (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .out_req(out_req), .out_data(out_data), .out_ack(out_ack),
        .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the run may not outlast the longest legal time for all tests together
    initial begin : watchdog
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles, a handshake is stuck", LIMIT);
        $display("Test failures found");
        $finish;
    end

    task automatic compare_word(input string name, input logic [WORD_W-1:0] exp,
                                input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, name, exp, act);
            errors++;
        end
    endtask

    // builds a word from its fields, good parity means an even number of ones
    function automatic logic [WORD_W-1:0] make_word(input logic cls, input logic [DATA_W-1:0] data,
                                                    input bit good);
        logic [WORD_W-1:0] w;
        w = '0;
        w[DATA_W-1:0] = data;
        w[PAR] = good ? ^data : ~^data;
        w[CLS] = cls;
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] random_data();
        logic [31:0] r;
        r = $urandom;
        return r[DATA_W-1:0];
    endfunction

    function automatic logic [WORD_W-1:0] random_word(input bit good);
        logic [31:0] r;
        r = $urandom;
        return make_word(r[31], r[DATA_W-1:0], good);
    endfunction

    task automatic raise_req(input logic [WORD_W-1:0] w);
        in_data = w; // held steady until the ack comes back
        in_req  = 1'b1;
    endtask

    // finishes the handshake and records the word in its lane model once acked
    task automatic complete_word();
        do @(negedge clk); while (!in_ack);
        if (in_data[CLS]) q1.push_back(in_data);
        else q0.push_back(in_data);
        sent++;
        in_req = 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    task automatic send_word(input logic [WORD_W-1:0] w, input int gap);
        raise_req(w);
        complete_word();
        repeat (gap) @(negedge clk);
    endtask

    // an output word must be the oldest outstanding word of its own lane
    task automatic check_output(input logic [WORD_W-1:0] w);
        logic [WORD_W-1:0] exp;
        bit                lane;
        lane = w[CLS];
        if ((lane && q1.size() == 0) || (!lane && q0.size() == 0)) begin
            $display("%s: output word %h has no outstanding word in lane %0d",
                     test_name, w, lane);
            errors++;
        end else begin
            if (lane) exp = q1.pop_front();
            else exp = q0.pop_front();
            compare_word("lane_order", exp, w);
        end
        out_log.push_back(w);
        received++;
    endtask

    // waits until every accepted word came out, bounded by the words still pending
    task automatic drain();
        int waited;
        int bound;
        waited = 0;
        bound  = 200 * (q0.size() + q1.size() + 1);
        while ((q0.size() != 0 || q1.size() != 0 || out_req || out_ack) && waited < bound) begin
            @(negedge clk);
            waited++;
        end
        if (q0.size() != 0 || q1.size() != 0) begin
            $display("%s: %0d accepted words never came out", test_name, q0.size() + q1.size());
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
        sent      = 0;
        received  = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("test %s: ok, %0d words", test_name, received);
        end else begin
            $display("test %s: %0d checks failed", test_name, errors - test_err0);
            tests_failed++;
        end
    endtask

    initial begin : consumer
        int delay;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack && !stall) begin
                delay = $urandom_range(max_delay, 0);
                repeat (delay) @(negedge clk);
                check_output(out_data);
                out_ack = 1'b1;
                do @(negedge clk); while (out_req); // req drops one edge after the ack
                out_ack = 1'b0;
            end
        end
    end

    initial begin : main
        bit acked;
        logic [WORD_W-1:0] w;
        void'($urandom(32'h25f4_d12b));
        in_req = 1'b0;
        in_data = '0;
        reset = 1'b0;
        stall = 1'b0;
        max_delay = 4;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (16) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        begin_test("random_traffic");
        compare_bit("in_ack_after_reset", 1'b0, in_ack);
        compare_bit("out_req_after_reset", 1'b0, out_req);
        compare_bit("error_after_reset", 1'b0, error);
        repeat (N_RANDOM) send_word(random_word(1'b1), $urandom_range(3, 0));
        drain();
        compare_count("words_out", sent, received);
        compare_bit("error_stays_low", 1'b0, error);
        end_test();

        // the merger holds one word and the lane 1 FIFO the next DEPTH, the one after waits
        begin_test("output_stall");
        stall = 1'b1;
        repeat (DEPTH + 1) send_word(make_word(1'b1, random_data(), 1'b1), 0);
        raise_req(make_word(1'b1, random_data(), 1'b1));
        acked = 1'b0;
        repeat (20) begin
            @(negedge clk);
            acked = acked | in_ack;
        end
        compare_bit("in_ack_withheld", 1'b0, acked);
        stall = 1'b0;
        complete_word();
        drain();
        compare_count("words_out", sent, received);
        end_test();

        begin_test("almost_full_first");
        stall = 1'b1;
        out_log.delete();
        lane0_words.delete();
        repeat (3) send_word(make_word(1'b1, random_data(), 1'b1), 1); // first sits in merger
        for (int i = 0; i < DEPTH; i++) begin
            w = make_word(1'b0, random_data(), 1'b1);
            lane0_words.push_back(w);
            send_word(w, 1);
        end
        repeat (4) @(negedge clk);
        stall = 1'b0;
        drain();
        compare_count("words_out", sent, received);
        // lane 0 stays urgent while its count is at or above AF_LEVEL
        if (out_log.size() < DEPTH - AF_LEVEL + 2) begin
            $display("%s: too few output words to check the read order", test_name);
            errors++;
        end else begin
            for (int i = 0; i < DEPTH - AF_LEVEL + 1; i++) begin
                compare_word("urgent_lane_first", lane0_words[i], out_log[i + 1]);
            end
        end
        end_test();

        begin_test("parity_error");
        max_delay = 2;
        compare_bit("error_before_bad_word", 1'b0, error);
        send_word(make_word(1'b0, random_data(), 1'b0), 0);
        compare_bit("error_after_bad_word", 1'b1, error);
        repeat (N_PARITY - 1) send_word(random_word(1'b1), $urandom_range(2, 0));
        drain();
        compare_count("words_out", sent, received);
        compare_bit("error_sticky", 1'b1, error);
        reset = 1'b0;
        repeat (16) @(negedge clk);
        compare_bit("error_in_reset", 1'b0, error);
        reset = 1'b1;
        @(negedge clk);
        compare_bit("error_cleared", 1'b0, error);
        end_test();

        $display("summary: %0d tests run, %0d tests failed, %0d checks failed",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: design/flow_top.sv
/*
 * top level of the two-lane flow path
 * splitter, one FIFO per lane, flow control and merger wired in a pipeline
 */

`timescale 1ns/1ps

module flow_top #(
    parameter int DATA_W   = 8,
    parameter int DEPTH    = 8,
    parameter int AF_LEVEL = 6,
    parameter int AE_LEVEL = 1
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_req,
    input  logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] in_data,
    output logic                                  in_ack,
    output logic                                  out_req,
    output logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] out_data,
    input  logic                                  out_ack,
    output logic                                  error
);

    logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] push_data;
    logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] head1;
    logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] head2;
    logic            push_0, push_1;
    logic            write1, write2, read1, read2;
    logic            full1, empty1, af1, ae1, err1;
    logic            full2, empty2, af2, ae2, err2;
    logic            rd_valid, take;
    flow_pkg::lane_e rd_lane;

    class_splitter #(.DATA_W(DATA_W)) u_split (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .push_0(push_0), .push_1(push_1), .push_data(push_data),
        .written(write1 | write2) // either lane taking the word completes the push
    );

    // FIFO 1 holds lane 0, FIFO 2 holds lane 1
    lane_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH), .AF_LEVEL(AF_LEVEL), .AE_LEVEL(AE_LEVEL))
    u_fifo1 (
        .clk(clk), .reset(reset), .write(write1), .read(read1),
        .wr_data(push_data), .rd_data(head1),
        .full(full1), .empty(empty1), .almost_full(af1), .almost_empty(ae1),
        .error(err1)
    );

    lane_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH), .AF_LEVEL(AF_LEVEL), .AE_LEVEL(AE_LEVEL))
    u_fifo2 (
        .clk(clk), .reset(reset), .write(write2), .read(read2),
        .wr_data(push_data), .rd_data(head2),
        .full(full2), .empty(empty2), .almost_full(af2), .almost_empty(ae2),
        .error(err2)
    );

    dfcontrol u_ctrl (
        .clk(clk), .reset(reset), .push_0(push_0), .push_1(push_1),
        .almost_full1(af1), .almost_empty1(ae1), .fifo_empty1(empty1),
        .fifo_full1(full1), .fifo_error1(err1),
        .almost_full2(af2), .almost_empty2(ae2), .fifo_empty2(empty2),
        .fifo_full2(full2), .fifo_error2(err2),
        .take(take), .write1(write1), .write2(write2), .read1(read1), .read2(read2),
        .rd_valid(rd_valid), .rd_lane(rd_lane), .error(error)
    );

    lane_merger #(.DATA_W(DATA_W)) u_merge (
        .clk(clk), .reset(reset), .rd_valid(rd_valid), .rd_lane(rd_lane),
        .head1(head1), .head2(head2), .take(take),
        .out_req(out_req), .out_data(out_data), .out_ack(out_ack)
    );

endmodule

// File: design/lane_merger.sv
/*
 * output side of the flow path
 * loads the head word of the lane picked by flow control into a holding
 * register and runs the output four-phase req/ack handshake
 */

`timescale 1ns/1ps

module lane_merger #(
    parameter int DATA_W = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  rd_valid,
    input  flow_pkg::lane_e                       rd_lane,
    input  logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] head1,
    input  logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] head2,
    output logic                                  take,
    output logic                                  out_req,
    output logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] out_data,
    input  logic                                  out_ack
);

    localparam logic [1:0] HM_EMPTY = 2'd0; // holding register free
    localparam logic [1:0] HM_REQ   = 2'd1; // word offered, req high
    localparam logic [1:0] HM_DONE  = 2'd2; // req dropped, waiting for ack low

    logic [1:0]                           state;
    logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] hold_data;

    assign take     = state == HM_EMPTY;
    assign out_req  = state == HM_REQ; // rises on the same edge as the load
    assign out_data = hold_data;

    // payload register, only loaded on a read
    always_ff @(posedge clk) begin
        if (take && rd_valid) begin
            hold_data <= (rd_lane == flow_pkg::LANE_0) ? head1 : head2;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= HM_EMPTY;
        end else begin
            case (state)
                HM_EMPTY: if (rd_valid) state <= HM_REQ;
                HM_REQ:   if (out_ack) state <= HM_DONE;   // req falls at this edge
                HM_DONE:  if (!out_ack) state <= HM_EMPTY; // room again once ack is low
                default:  state <= HM_EMPTY;
            endcase
        end
    end

    // the consumer only acks a word that was offered
    a_ack_after_req: assert property (@(posedge clk) disable iff (!reset)
        out_ack |-> state != HM_EMPTY);

    // flow control only reads when there is room here
    a_read_has_room: assert property (@(posedge clk) disable iff (!reset)
        rd_valid |-> take);

endmodule

// File: design/dfcontrol.sv
/*
 * flow control between the splitter, the two FIFOs and the merger
 * write gating against full FIFOs, read selection between the lanes
 * and the merged error output
 */

`timescale 1ns/1ps

module dfcontrol (
    input  logic            clk,
    input  logic            reset,
    input  logic            push_0,
    input  logic            push_1,
    input  logic            almost_full1,
    input  logic            almost_empty1,
    input  logic            fifo_empty1,
    input  logic            fifo_full1,
    input  logic            fifo_error1,
    input  logic            almost_full2,
    input  logic            almost_empty2,
    input  logic            fifo_empty2,
    input  logic            fifo_full2,
    input  logic            fifo_error2,
    input  logic            take,
    output logic            write1,
    output logic            write2,
    output logic            read1,
    output logic            read2,
    output logic            rd_valid,
    output flow_pkg::lane_e rd_lane,
    output logic            error
);

    flow_pkg::lane_e last;   // lane served by the previous read
    logic            urg1;
    logic            urg2;
    logic            cand1;
    logic            cand2;

    assign write1 = push_0 && !fifo_full1; // a push into a full FIFO just waits
    assign write2 = push_1 && !fifo_full2;
    assign error  = reset && (fifo_error1 || fifo_error2); // held low in reset

    // a lane near full goes first, otherwise every non-empty lane competes
    assign urg1  = !fifo_empty1 && almost_full1;
    assign urg2  = !fifo_empty2 && almost_full2;
    assign cand1 = (urg1 || urg2) ? urg1 : !fifo_empty1;
    assign cand2 = (urg1 || urg2) ? urg2 : !fifo_empty2;

    always_comb begin
        if (cand1 && cand2) begin
            rd_lane = (last == flow_pkg::LANE_0) ? flow_pkg::LANE_1 : flow_pkg::LANE_0;
        end else begin
            rd_lane = cand2 ? flow_pkg::LANE_1 : flow_pkg::LANE_0;
        end
    end

    assign rd_valid = take && (cand1 || cand2); // the merger must have room
    assign read1    = rd_valid && rd_lane == flow_pkg::LANE_0;
    assign read2    = rd_valid && rd_lane == flow_pkg::LANE_1;

    always_ff @(posedge clk) begin
        if (!reset) begin
            last <= flow_pkg::LANE_1; // so lane 0 is served first on a tie
        end else if (rd_valid) begin
            last <= rd_lane;
        end
    end

    // the splitter pushes into one lane at a time
    a_one_push: assert property (@(posedge clk) disable iff (!reset)
        !(push_0 && push_1));

    // an empty FIFO must not also claim to be almost empty or near full
    a_flags1: assert property (@(posedge clk) disable iff (!reset)
        fifo_empty1 |-> !almost_empty1 && !almost_full1 && !fifo_full1);

    a_flags2: assert property (@(posedge clk) disable iff (!reset)
        fifo_empty2 |-> !almost_empty2 && !almost_full2 && !fifo_full2);

endmodule

// File: design/lane_fifo.sv
/*
 * first-word-fall-through FIFO for one lane
 * full, empty, almost-full and almost-empty flags from an occupancy count
 * sticky error when a word with bad parity is written
 */

`timescale 1ns/1ps

module lane_fifo #(
    parameter int DATA_W   = 8,
    parameter int DEPTH    = 8,
    parameter int AF_LEVEL = 6,
    parameter int AE_LEVEL = 1
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  write,
    input  logic                                  read,
    input  logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] wr_data,
    output logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] rd_data,
    output logic                                  full,
    output logic                                  empty,
    output logic                                  almost_full,
    output logic                                  almost_empty,
    output logic                                  error
);

    localparam int WORD_W = DATA_W + flow_pkg::WORD_EXTRA;
    localparam int AW     = $clog2(DEPTH);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;  // one extra bit so DEPTH itself fits
    logic              do_wr;
    logic              do_rd;
    logic              bad_parity;

    // internal strobes never move the count past full or empty
    assign do_wr = write && !full;
    assign do_rd = read && !empty;

    // odd number of ones over data plus parity bit
    assign bad_parity = ^{wr_data[DATA_W + flow_pkg::PARITY_POS], wr_data[DATA_W-1:0]};

    assign rd_data      = mem[rd_ptr]; // head word falls through
    assign full         = count == DEPTH;
    assign empty        = count == 0;
    assign almost_full  = count >= AF_LEVEL;
    assign almost_empty = count <= AE_LEVEL && count != 0; // empty is flagged on its own

    // storage is written at the tail pointer
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            error  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave it as is
            endcase
            if (do_wr && bad_parity) error <= 1'b1; // sticky until reset
        end
    end

    // flow control must never ask for more than the FIFO can do
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
        write |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset)
        read |-> !empty);

endmodule

// File: design/class_splitter.sv
/*
 * input side of the flow path
 * runs the four-phase req/ack handshake with the producer and turns
 * each accepted word into one push for the lane named by its class bit
 */

`timescale 1ns/1ps

module class_splitter #(
    parameter int DATA_W = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_req,
    input  logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] in_data,
    output logic                                  in_ack,
    output logic                                  push_0,
    output logic                                  push_1,
    output logic [DATA_W+flow_pkg::WORD_EXTRA-1:0] push_data,
    input  logic                                  written
);

    localparam logic [1:0] ST_IDLE  = 2'd0; // waiting for in_req
    localparam logic [1:0] ST_PUSH  = 2'd1; // push held, target FIFO was full
    localparam logic [1:0] ST_ACKED = 2'd2; // word written, ack up until req drops

    logic [1:0]      state;
    logic            push_any;
    flow_pkg::lane_e lane;

    // a push is live from the first cycle of req until the write lands
    assign push_any = (state == ST_IDLE && in_req) || state == ST_PUSH;
    assign lane     = flow_pkg::lane_e'(in_data[DATA_W + flow_pkg::CLASS_POS]);
    assign push_0   = push_any && lane == flow_pkg::LANE_0;
    assign push_1   = push_any && lane == flow_pkg::LANE_1;
    assign push_data = in_data; // both FIFOs see the word, only one gets the write
    assign in_ack   = state == ST_ACKED; // rises on the edge that performs the write

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (in_req) state <= written ? ST_ACKED : ST_PUSH;
                ST_PUSH:  if (written) state <= ST_ACKED; // back-pressure keeps us here
                ST_ACKED: if (!in_req) state <= ST_IDLE;  // ack falls on this edge
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // flow control reports a write only while this side is pushing
    a_write_has_push: assert property (@(posedge clk) disable iff (!reset)
        written |-> push_0 || push_1);

    // while a push is stalled the producer must keep req and the word steady
    a_req_held: assert property (@(posedge clk) disable iff (!reset)
        state == ST_PUSH |-> in_req && $stable(in_data));

endmodule

// File: design/flow_pkg.sv
/*
 * shared definitions for the two-lane flow path
 * lane_e names a lane in the splitter, flow control and merger
 * word layout offsets for the class and parity bits
 */

package flow_pkg;

    // one bit is enough to name either lane
    typedef enum logic {
        LANE_0 = 1'b0, // class bit low goes to FIFO 1
        LANE_1 = 1'b1  // class bit high goes to FIFO 2
    } lane_e;

    // a word is the data field plus these extra bits on top
    localparam int WORD_EXTRA = 2;

    // the positions below are counted from the top of the data field,
    // so bit DATA_W + CLASS_POS of a word is its class bit
    localparam int CLASS_POS  = 1; // top bit of the word
    localparam int PARITY_POS = 0; // just below the class bit

    // even parity covers the data field plus the parity bit
    // an odd number of ones there marks the word as bad

endpackage
